// File: vlog.f
src/tcls_pkg.sv
src/tmr_voter.sv
src/tcls_regs.sv
src/tcls_unit.sv
src/mem_arbiter.sv
src/data_mem.sv
src/tcls_top.sv
dv/tcls_tb.sv

// File: Bender.yml
package:
  name: tcls

sources:
  - src/tcls_pkg.sv
  - src/tmr_voter.sv
  - src/tcls_regs.sv
  - src/tcls_unit.sv
  - src/mem_arbiter.sv
  - src/data_mem.sv
  - src/tcls_top.sv
  - target: simulation
    files:
      - dv/tcls_tb.sv

// File: dv/tcls_tb.sv
// Lockstep subsystem testbench
`timescale 1ns/1ps
`default_nettype none

module tcls_tb;

  import tcls_pkg::*;

  // Several times the length of all tests together
  localparam int unsigned TimeoutCycles = 2000;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         fetch_en;
  main_payload_t [NumCores-1:0] core_main;
  data_payload_t [NumCores-1:0] core_data;
  mem_rsp_t                     core_rsp;
  mem_req_t                     host_req;
  mem_rsp_t                     host_rsp;
  reg_req_t                     reg_req;
  reg_rsp_t                     reg_rsp;
  logic                         irq_ack;
  logic [4:0]                   irq_ack_id;
  logic                         single_mismatch;
  logic                         triple_mismatch;

  logic [31:0] shadow [MemWords];
  logic [31:0] rng = 32'd55;
  int unsigned cycle_count = 0;

  tcls_top UUT (
    .clk_i             ( clk_i           ),
    .rst_ni            ( rst_ni          ),
    .fetch_en_i        ( fetch_en        ),
    .core_main_i       ( core_main       ),
    .core_data_i       ( core_data       ),
    .core_rsp_o        ( core_rsp        ),
    .host_req_i        ( host_req        ),
    .host_rsp_o        ( host_rsp        ),
    .reg_req_i         ( reg_req         ),
    .reg_rsp_o         ( reg_rsp         ),
    .intc_irq_ack_o    ( irq_ack         ),
    .intc_irq_ack_id_o ( irq_ack_id      ),
    .single_mismatch_o ( single_mismatch ),
    .triple_mismatch_o ( triple_mismatch )
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count++;
    if (cycle_count >= TimeoutCycles) begin
      $display("timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("sim failed");
      $fatal(1);
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      $display("mismatch time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  task automatic idle_cores();
    core_main = '0;
    core_data = '0;
  endtask

  task automatic apply_reset();
    rst_ni   = 1'b0;
    fetch_en = 1'b0;
    idle_cores();
    host_req = '0;
    reg_req  = '0;
    repeat (3) @(posedge clk_i);
    #1;
    rst_ni   = 1'b1;
    fetch_en = 1'b1;
  endtask

  // Byte-enable merge into the reference memory
  task automatic shadow_write(input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [3:0] be, output logic [31:0] word);
    word = shadow[addr[9:2]];
    for (int i = 0; i < 4; i++) begin
      if (be[i]) begin
        word[8*i +: 8] = wdata[8*i +: 8];
      end
    end
    shadow[addr[9:2]] = word;
  endtask

  task automatic drive_cores(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] be);
    for (int i = 0; i < NumCores; i++) begin
      core_main[i].irq_ack    = 1'b0;
      core_main[i].irq_ack_id = 5'd0;
      core_main[i].data_req   = 1'b1;
      core_data[i].addr       = addr;
      core_data[i].we         = we;
      core_data[i].wdata      = wdata;
      core_data[i].be         = be;
    end
  endtask

  // One core access with an optional stray address on one core
  task automatic core_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] be,
                             input int bad_core, input logic [31:0] addr_flip);
    logic [31:0] expected;
    logic        faulty;
    faulty = (bad_core >= 0) && (addr_flip != '0);
    next_cycle();
    drive_cores(we, addr, wdata, be);
    if (faulty) begin
      core_data[bad_core].addr = addr ^ addr_flip;
    end
    #1;
    check_value("single_mismatch_o", single_mismatch, faulty);
    check_value("triple_mismatch_o", triple_mismatch, faulty);
    check_value("core_rsp_o.valid", core_rsp.valid, 1'b0);
    if (we) begin
      shadow_write(addr, wdata, be, expected);
    end else begin
      expected = shadow[addr[9:2]];
    end
    next_cycle();
    idle_cores();
    check_value("core_rsp_o.valid", core_rsp.valid, 1'b1);
    check_value("core_rsp_o.rdata", core_rsp.rdata, expected);
  endtask

  task automatic host_access(input logic we, input logic [31:0] addr,
                             input logic [31:0] wdata, input logic [3:0] be);
    logic [31:0] expected;
    next_cycle();
    host_req.valid = 1'b1;
    host_req.we    = we;
    host_req.addr  = addr;
    host_req.wdata = wdata;
    host_req.be    = be;
    if (we) begin
      shadow_write(addr, wdata, be, expected);
    end else begin
      expected = shadow[addr[9:2]];
    end
    next_cycle();
    host_req = '0;
    check_value("host_rsp_o.valid", host_rsp.valid, 1'b1);
    check_value("host_rsp_o.rdata", host_rsp.rdata, expected);
  endtask

  // Core and host in the same cycle with the host deferred by one
  task automatic collide(input logic c_we, input logic [31:0] c_addr,
                         input logic [31:0] c_wdata, input logic h_we,
                         input logic [31:0] h_addr, input logic [31:0] h_wdata,
                         input logic [3:0] h_be);
    logic [31:0] core_exp;
    logic [31:0] host_exp;
    next_cycle();
    drive_cores(c_we, c_addr, c_wdata, 4'hf);
    host_req.valid = 1'b1;
    host_req.we    = h_we;
    host_req.addr  = h_addr;
    host_req.wdata = h_wdata;
    host_req.be    = h_be;
    if (c_we) begin
      shadow_write(c_addr, c_wdata, 4'hf, core_exp);
    end else begin
      core_exp = shadow[c_addr[9:2]];
    end
    if (h_we) begin
      shadow_write(h_addr, h_wdata, h_be, host_exp);
    end else begin
      host_exp = shadow[h_addr[9:2]];
    end
    next_cycle();
    idle_cores();
    host_req = '0;
    check_value("core_rsp_o.valid", core_rsp.valid, 1'b1);
    check_value("core_rsp_o.rdata", core_rsp.rdata, core_exp);
    check_value("host_rsp_o.valid", host_rsp.valid, 1'b0);
    next_cycle();
    check_value("host_rsp_o.valid", host_rsp.valid, 1'b1);
    check_value("host_rsp_o.rdata", host_rsp.rdata, host_exp);
    check_value("core_rsp_o.valid", core_rsp.valid, 1'b0);
  endtask

  task automatic reg_access(input logic write, input logic [RegAddrBits-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    next_cycle();
    reg_req.valid = 1'b1;
    reg_req.write = write;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    next_cycle();
    reg_req = '0;
    check_value("reg_rsp_o.valid", reg_rsp.valid, 1'b1);
    rdata = reg_rsp.rdata;
  endtask

  task automatic reg_write(input logic [RegAddrBits-1:0] addr, input logic [31:0] wdata);
    logic [31:0] unused;
    reg_access(1'b1, addr, wdata, unused);
  endtask

  task automatic reg_expect(input string name, input logic [RegAddrBits-1:0] addr,
                            input logic [31:0] exp);
    logic [31:0] rdata;
    reg_access(1'b0, addr, 32'd0, rdata);
    check_value(name, rdata, exp);
  endtask

  // Single-cycle disagreement on irq_ack_id of one core
  task automatic inject_mismatch(input int bad_core);
    next_cycle();
    idle_cores();
    core_main[bad_core].irq_ack_id = 5'b00100;
    #1;
    check_value("single_mismatch_o", single_mismatch, 1'b1);
    check_value("triple_mismatch_o", triple_mismatch, 1'b1);
    next_cycle();
    idle_cores();
  endtask

  task automatic irq_ack_check(input logic exp_ack, input logic [4:0] exp_id);
    next_cycle();
    for (int i = 0; i < NumCores; i++) begin
      core_main[i].irq_ack    = 1'b1;
      core_main[i].irq_ack_id = 5'd9;
    end
    #1;
    check_value("intc_irq_ack_o", irq_ack, exp_ack);
    check_value("intc_irq_ack_id_o", irq_ack_id, exp_id);
    next_cycle();
    idle_cores();
  endtask

  task automatic agreeing_rw();
    logic [31:0] addrs [8];
    for (int i = 0; i < 8; i++) begin
      rng = xorshift32(rng);
      addrs[i] = {22'd0, rng[7:0], 2'b00};
      rng = xorshift32(rng);
      core_access(1'b1, addrs[i], rng, 4'hf, -1, '0);
    end
    // Partial writes over defined words
    for (int i = 0; i < 8; i++) begin
      rng = xorshift32(rng);
      core_access(1'b1, addrs[i], rng, rng[3:0], -1, '0);
    end
    for (int i = 0; i < 8; i++) begin
      core_access(1'b0, addrs[i], 32'd0, 4'h0, -1, '0);
    end
  endtask

  task automatic single_core_fault();
    apply_reset();
    rng = xorshift32(rng);
    core_access(1'b1, 32'h100, rng, 4'hf, -1, '0);
    core_access(1'b1, 32'h110, 32'ha5a5_5a5a, 4'hf, -1, '0);
    // Stray address without a data request is ignored
    next_cycle();
    core_data[1].addr = 32'h110;
    #1;
    check_value("single_mismatch_o", single_mismatch, 1'b0);
    check_value("triple_mismatch_o", triple_mismatch, 1'b0);
    next_cycle();
    idle_cores();
    rng = xorshift32(rng);
    core_access(1'b1, 32'h100, rng, 4'hf, 1, 32'h10);
    core_access(1'b0, 32'h100, 32'd0, 4'h0, -1, '0);
    core_access(1'b0, 32'h110, 32'd0, 4'h0, -1, '0);
    reg_expect("mismatch0", REG_MISMATCH0, 32'd0);
    reg_expect("mismatch1", REG_MISMATCH1, 32'd1);
    reg_expect("mismatch2", REG_MISMATCH2, 32'd0);
  endtask

  task automatic all_cores_differ();
    next_cycle();
    for (int i = 0; i < NumCores; i++) begin
      core_main[i].irq_ack    = 1'b1;
      core_main[i].irq_ack_id = 5'd1 << i;
    end
    #1;
    check_value("triple_mismatch_o", triple_mismatch, 1'b1);
    next_cycle();
    idle_cores();
  endtask

  task automatic recovery_sequence();
    apply_reset();
    reg_write(REG_MODE, 32'd0);
    inject_mismatch(2);
    reg_expect("status", REG_STATUS, UNLOAD);
    irq_ack_check(1'b0, 5'd0);
    rng = xorshift32(rng);
    reg_write(REG_SP_STORE, rng | 32'd1);
    reg_expect("status", REG_STATUS, RELOAD);
    irq_ack_check(1'b1, 5'd9);
    reg_write(REG_SP_STORE, 32'd0);
    reg_expect("status", REG_STATUS, RUN);
    reg_write(REG_MODE, 32'd1);
    reg_expect("restore_mode", REG_MODE, 32'd1);
    inject_mismatch(2);
    reg_expect("status", REG_STATUS, RUN);
    reg_expect("mismatch2", REG_MISMATCH2, 32'd2);
  endtask

  task automatic host_core_collision();
    rng = xorshift32(rng);
    host_access(1'b1, 32'h200, rng, 4'hf);
    rng = xorshift32(rng);
    collide(1'b0, 32'h100, 32'd0, 1'b1, 32'h200, rng, 4'b0110);
    rng = xorshift32(rng);
    collide(1'b1, 32'h110, rng, 1'b0, 32'h200, 32'd0, 4'h0);
    host_access(1'b0, 32'h110, 32'd0, 4'h0);
    core_access(1'b0, 32'h200, 32'd0, 4'h0, -1, '0);
  endtask

  task automatic fetch_en_drop();
    apply_reset();
    inject_mismatch(0);
    reg_expect("status", REG_STATUS, UNLOAD);
    next_cycle();
    fetch_en = 1'b0;
    reg_expect("status", REG_STATUS, RUN);
    fetch_en = 1'b1;
  endtask

  initial begin
    rst_ni   = 1'b0;
    fetch_en = 1'b0;
    idle_cores();
    host_req = '0;
    reg_req  = '0;
    apply_reset();
    agreeing_rw();
    single_core_fault();
    all_cores_differ();
    recovery_sequence();
    host_core_collision();
    fetch_en_drop();
    $display("sim passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: src/tcls_top.sv
// Lockstep subsystem top level
`timescale 1ns/1ps
`default_nettype none

module tcls_top (
  input  logic                                             clk_i,
  input  logic                                             rst_ni,
  input  logic                                             fetch_en_i,
  input  tcls_pkg::main_payload_t [tcls_pkg::NumCores-1:0] core_main_i,
  input  tcls_pkg::data_payload_t [tcls_pkg::NumCores-1:0] core_data_i,
  output tcls_pkg::mem_rsp_t                               core_rsp_o,
  input  tcls_pkg::mem_req_t                               host_req_i,
  output tcls_pkg::mem_rsp_t                               host_rsp_o,
  input  tcls_pkg::reg_req_t                               reg_req_i,
  output tcls_pkg::reg_rsp_t                               reg_rsp_o,
  output logic                                             intc_irq_ack_o,
  output logic [4:0]                                       intc_irq_ack_id_o,
  output logic                                             single_mismatch_o,
  output logic                                             triple_mismatch_o
);

  import tcls_pkg::*;

  mem_req_t   core_mem_req, mem_req;
  mem_rsp_t   core_mem_rsp, mem_rsp;
  logic       restore_mode;
  logic [31:0] sp_store;
  logic [2:0] mismatch_inc;
  red_mode_e  mode;

  tcls_unit i_unit (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .fetch_en_i        ( fetch_en_i        ),
    .core_main_i       ( core_main_i       ),
    .core_data_i       ( core_data_i       ),
    .core_rsp_o        ( core_rsp_o        ),
    .mem_req_o         ( core_mem_req      ),
    .mem_rsp_i         ( core_mem_rsp      ),
    .intc_irq_ack_o    ( intc_irq_ack_o    ),
    .intc_irq_ack_id_o ( intc_irq_ack_id_o ),
    .single_mismatch_o ( single_mismatch_o ),
    .triple_mismatch_o ( triple_mismatch_o ),
    .mismatch_inc_o    ( mismatch_inc      ),
    .restore_mode_i    ( restore_mode      ),
    .sp_store_i        ( sp_store          ),
    .mode_o            ( mode              )
  );

  tcls_regs i_regs (
    .clk_i          ( clk_i        ),
    .rst_ni         ( rst_ni       ),
    .reg_req_i      ( reg_req_i    ),
    .reg_rsp_o      ( reg_rsp_o    ),
    .restore_mode_o ( restore_mode ),
    .sp_store_o     ( sp_store     ),
    .mismatch_inc_i ( mismatch_inc ),
    .mode_i         ( mode         )
  );

  mem_arbiter i_arbiter (
    .clk_i      ( clk_i        ),
    .rst_ni     ( rst_ni       ),
    .core_req_i ( core_mem_req ),
    .host_req_i ( host_req_i   ),
    .core_rsp_o ( core_mem_rsp ),
    .host_rsp_o ( host_rsp_o   ),
    .mem_req_o  ( mem_req      ),
    .mem_rsp_i  ( mem_rsp      )
  );

  data_mem i_mem (
    .clk_i  ( clk_i   ),
    .rst_ni ( rst_ni  ),
    .req_i  ( mem_req ),
    .rsp_o  ( mem_rsp )
  );

endmodule

`default_nettype wire

// File: src/data_mem.sv
// Shared data memory
`timescale 1ns/1ps
`default_nettype none

module data_mem (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  tcls_pkg::mem_req_t req_i,
  output tcls_pkg::mem_rsp_t rsp_o
);

  import tcls_pkg::*;

  logic [31:0]            mem_q [MemWords];
  logic [MemAddrBits-1:0] idx;
  logic [31:0]            merged;
  logic                   rsp_valid_q;
  logic [31:0]            rdata_q;

  // Word index from byte address
  assign idx = req_i.addr[MemAddrBits+1:2];

  // Stored word with the enabled bytes replaced
  always_comb begin
    merged = mem_q[idx];
    for (int i = 0; i < 4; i++) begin
      if (req_i.be[i]) begin
        merged[8*i +: 8] = req_i.wdata[8*i +: 8];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i.valid) begin
      if (req_i.we) begin
        mem_q[idx] <= merged;
        rdata_q    <= merged;
      end else begin
        rdata_q <= mem_q[idx];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= req_i.valid;
    end
  end

  assign rsp_o.valid = rsp_valid_q;
  assign rsp_o.rdata = rdata_q;

endmodule

`default_nettype wire

// File: src/mem_arbiter.sv
// Core and host memory arbiter
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  tcls_pkg::mem_req_t core_req_i,
  input  tcls_pkg::mem_req_t host_req_i,
  output tcls_pkg::mem_rsp_t core_rsp_o,
  output tcls_pkg::mem_rsp_t host_rsp_o,
  output tcls_pkg::mem_req_t mem_req_o,
  input  tcls_pkg::mem_rsp_t mem_rsp_i
);

  import tcls_pkg::*;

  mem_req_t slot_req_q;
  logic     slot_valid_q;
  logic     host_issue;
  logic     owner_host_q;

  // Core first, then the deferred host request, then a fresh one
  always_comb begin
    host_issue = 1'b0;
    if (core_req_i.valid) begin
      mem_req_o = core_req_i;
    end else if (slot_valid_q) begin
      mem_req_o  = slot_req_q;
      host_issue = 1'b1;
    end else begin
      mem_req_o  = host_req_i;
      host_issue = host_req_i.valid;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_valid_q <= 1'b0;
      owner_host_q <= 1'b0;
    end else begin
      if (core_req_i.valid) begin
        slot_valid_q <= slot_valid_q | host_req_i.valid;
      end else begin
        slot_valid_q <= 1'b0;
      end
      owner_host_q <= host_issue;
    end
  end

  // Colliding host request waits one cycle
  always_ff @(posedge clk_i) begin
    if (core_req_i.valid && host_req_i.valid) begin
      slot_req_q <= host_req_i;
    end
  end

  assign core_rsp_o.valid = mem_rsp_i.valid & ~owner_host_q;
  assign core_rsp_o.rdata = mem_rsp_i.rdata;
  assign host_rsp_o.valid = mem_rsp_i.valid & owner_host_q;
  assign host_rsp_o.rdata = mem_rsp_i.rdata;

endmodule

`default_nettype wire

// File: src/tcls_unit.sv
// Triple-core lockstep unit
`timescale 1ns/1ps
`default_nettype none

module tcls_unit (
  input  logic                                                 clk_i,
  input  logic                                                 rst_ni,
  input  logic                                                 fetch_en_i,
  input  tcls_pkg::main_payload_t [tcls_pkg::NumCores-1:0]     core_main_i,
  input  tcls_pkg::data_payload_t [tcls_pkg::NumCores-1:0]     core_data_i,
  output tcls_pkg::mem_rsp_t                                   core_rsp_o,
  output tcls_pkg::mem_req_t                                   mem_req_o,
  input  tcls_pkg::mem_rsp_t                                   mem_rsp_i,
  output logic                                                 intc_irq_ack_o,
  output logic [4:0]                                           intc_irq_ack_id_o,
  output logic                                                 single_mismatch_o,
  output logic                                                 triple_mismatch_o,
  output logic [2:0]                                           mismatch_inc_o,
  input  logic                                                 restore_mode_i,
  input  logic [31:0]                                          sp_store_i,
  output tcls_pkg::red_mode_e                                  mode_o
);

  import tcls_pkg::*;

  main_payload_t main_voted;
  data_payload_t data_voted;
  logic          main_err, data_err;
  logic [2:0]    main_cba, data_cba;
  logic          tmr_err;
  logic [2:0]    tmr_cba;
  red_mode_e     mode_d, mode_q;

  // Control fields are voted every cycle
  tmr_voter #(
    .payload_t ( main_payload_t )
  ) i_main_voter (
    .a_i         ( core_main_i[0] ),
    .b_i         ( core_main_i[1] ),
    .c_i         ( core_main_i[2] ),
    .majority_o  ( main_voted     ),
    .error_o     ( main_err       ),
    .error_cba_o ( main_cba       )
  );

  // Data fields only count while a data request is issued
  tmr_voter #(
    .payload_t ( data_payload_t )
  ) i_data_voter (
    .a_i         ( core_data_i[0] ),
    .b_i         ( core_data_i[1] ),
    .c_i         ( core_data_i[2] ),
    .majority_o  ( data_voted     ),
    .error_o     ( data_err       ),
    .error_cba_o ( data_cba       )
  );

  always_comb begin
    tmr_err = main_err;
    tmr_cba = main_cba;
    if (main_voted.data_req) begin
      tmr_err = main_err | data_err;
      tmr_cba = main_cba | data_cba;
    end
  end

  assign single_mismatch_o = |tmr_cba;
  assign triple_mismatch_o = tmr_err;

  // Counters only see disagreements while running
  assign mismatch_inc_o = (mode_q == RUN) ? tmr_cba : 3'b000;

  // Recovery controller
  always_comb begin
    mode_d = mode_q;
    case (mode_q)
      RUN: begin
        if (|tmr_cba && !restore_mode_i) begin
          mode_d = UNLOAD;
        end
      end
      UNLOAD: begin
        // Software has saved its context
        if (sp_store_i != '0) begin
          mode_d = RELOAD;
        end
      end
      RELOAD: begin
        if (sp_store_i == '0) begin
          mode_d = RUN;
        end
      end
      default: mode_d = RUN;
    endcase
    // Cores not started, stay in RUN
    if (!fetch_en_i) begin
      mode_d = RUN;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mode_q <= RUN;
    end else begin
      mode_q <= mode_d;
    end
  end

  assign mode_o = mode_q;

  // Interrupt acknowledge is held back while unloading
  always_comb begin
    intc_irq_ack_o    = main_voted.irq_ack;
    intc_irq_ack_id_o = main_voted.irq_ack_id;
    if (mode_q == UNLOAD) begin
      intc_irq_ack_o    = 1'b0;
      intc_irq_ack_id_o = 5'd0;
    end
  end

  // Voted data request toward memory
  always_comb begin
    mem_req_o.valid = main_voted.data_req;
    mem_req_o.we    = data_voted.we;
    mem_req_o.addr  = data_voted.addr;
    mem_req_o.wdata = data_voted.wdata;
    mem_req_o.be    = data_voted.be;
  end

  // Same response for all three cores
  assign core_rsp_o = mem_rsp_i;

endmodule

`default_nettype wire

// File: src/tcls_regs.sv
// Lockstep control registers
`timescale 1ns/1ps
`default_nettype none

module tcls_regs (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  tcls_pkg::reg_req_t reg_req_i,
  output tcls_pkg::reg_rsp_t reg_rsp_o,
  output logic               restore_mode_o,
  output logic [31:0]        sp_store_o,
  input  logic [2:0]         mismatch_inc_i,
  input  tcls_pkg::red_mode_e mode_i
);

  import tcls_pkg::*;

  logic                    restore_mode_q;
  logic [31:0]             sp_store_q;
  logic [NumCores-1:0][31:0] mismatch_q;
  logic [31:0]             rdata;
  logic                    rsp_valid_q;
  logic [31:0]             rsp_rdata_q;

  // Read decode, unmapped addresses return zero
  always_comb begin
    rdata = '0;
    case (reg_req_i.addr)
      REG_MODE:      rdata = {31'd0, restore_mode_q};
      REG_SP_STORE:  rdata = sp_store_q;
      REG_MISMATCH0: rdata = mismatch_q[0];
      REG_MISMATCH1: rdata = mismatch_q[1];
      REG_MISMATCH2: rdata = mismatch_q[2];
      REG_STATUS:    rdata = {30'd0, mode_i};
      default:       rdata = '0;
    endcase
  end

  // Writable registers, read-only addresses ignore writes
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      restore_mode_q <= 1'b0;
      sp_store_q     <= '0;
    end else if (reg_req_i.valid && reg_req_i.write) begin
      if (reg_req_i.addr == REG_MODE) begin
        restore_mode_q <= reg_req_i.wdata[0];
      end
      if (reg_req_i.addr == REG_SP_STORE) begin
        sp_store_q <= reg_req_i.wdata;
      end
    end
  end

  // Per-core mismatch counters, wrap on overflow
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mismatch_q <= '0;
    end else begin
      for (int i = 0; i < NumCores; i++) begin
        if (mismatch_inc_i[i]) begin
          mismatch_q[i] <= mismatch_q[i] + 32'd1;
        end
      end
    end
  end

  // Response one cycle after the request
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= reg_req_i.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reg_req_i.valid) begin
      rsp_rdata_q <= reg_req_i.write ? 32'd0 : rdata;
    end
  end

  assign reg_rsp_o.valid = rsp_valid_q;
  assign reg_rsp_o.rdata = rsp_rdata_q;
  assign restore_mode_o  = restore_mode_q;
  assign sp_store_o      = sp_store_q;

endmodule

`default_nettype wire

// File: src/tmr_voter.sv
// Bitwise majority voter
`timescale 1ns/1ps
`default_nettype none

module tmr_voter #(
  parameter type payload_t = logic
) (
  input  payload_t   a_i,
  input  payload_t   b_i,
  input  payload_t   c_i,
  output payload_t   majority_o,
  output logic       error_o,
  output logic [2:0] error_cba_o
);

  localparam int unsigned Width = $bits(payload_t);

  logic [Width-1:0] a, b, c;
  logic [Width-1:0] vote;

  assign a = a_i;
  assign b = b_i;
  assign c = c_i;

  // Two out of three per bit
  assign vote       = (a & b) | (a & c) | (b & c);
  assign majority_o = payload_t'(vote);

  // A core is flagged when it alone differs from the other two on some bit
  assign error_cba_o[0] = |((a ^ b) & (a ^ c));
  assign error_cba_o[1] = |((b ^ a) & (b ^ c));
  assign error_cba_o[2] = |((c ^ a) & (c ^ b));

  // Any bit that is not unanimous
  assign error_o = |((a ^ b) | (a ^ c));

endmodule

`default_nettype wire

// File: src/tcls_pkg.sv
// Lockstep subsystem shared types
`default_nettype none

package tcls_pkg;

  // Redundancy and memory geometry
  localparam int unsigned NumCores    = 3;
  localparam int unsigned MemWords    = 256;
  localparam int unsigned MemAddrBits = 8;
  localparam int unsigned RegAddrBits = 3;

  // Register map
  localparam logic [RegAddrBits-1:0] REG_MODE      = 3'd0;
  localparam logic [RegAddrBits-1:0] REG_SP_STORE  = 3'd1;
  localparam logic [RegAddrBits-1:0] REG_MISMATCH0 = 3'd2;
  localparam logic [RegAddrBits-1:0] REG_MISMATCH1 = 3'd3;
  localparam logic [RegAddrBits-1:0] REG_MISMATCH2 = 3'd4;
  localparam logic [RegAddrBits-1:0] REG_STATUS    = 3'd5;

  // Control fields, voted every cycle
  typedef struct packed {
    logic       irq_ack;
    logic [4:0] irq_ack_id;
    logic       data_req;
  } main_payload_t;

  // Data bus fields, only meaningful while data_req is set
  typedef struct packed {
    logic [31:0] addr;
    logic        we;
    logic [31:0] wdata;
    logic [3:0]  be;
  } data_payload_t;

  typedef struct packed {
    logic        valid;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [3:0]  be;
  } mem_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic                   valid;
    logic                   write;
    logic [RegAddrBits-1:0] addr;
    logic [31:0]            wdata;
  } reg_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
  } reg_rsp_t;

  // Recovery controller state
  typedef enum logic [1:0] {
    RUN    = 2'd0,
    UNLOAD = 2'd1,
    RELOAD = 2'd2
  } red_mode_e;

endpackage

`default_nettype wire
